//--- common/mcr3_pkg.sv
// MCR3 control shared definitions
package mcr3_pkg;

	// ======================================================================
	// Game codes and download indexes
	// ======================================================================

	// Any code outside these four selects no game
	typedef enum logic [7:0] {
		game_tapper  = 8'd0,
		game_timber  = 8'd1,
		game_dotron  = 8'd2,
		game_journey = 8'd3
	} game_t;

	localparam logic [7:0] idx_rom  = 8'd0;
	localparam logic [7:0] idx_mode = 8'd1;
	localparam logic [7:0] idx_dip  = 8'd254;

	localparam int spin_w = 9;

	// ======================================================================
	// Bundled signals
	// ======================================================================

	// One beat of the download stream
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_write_t;

	// Player control word, right is bit 0
	typedef struct packed {
		logic        spin_cw;
		logic        spin_ccw;
		logic [16:0] reserved;
		logic        coin;
		logic        start2;
		logic        start1;
		logic        rot_ccw;
		logic        rot_cw;
		logic        fire_d;
		logic        fire_c;
		logic        fire_b;
		logic        fire_a;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
	} joy_word_t;

	// Port 1 carries buttons on most games and a spinner on dotron
	typedef union packed {
		logic [7:0] btn;
		struct packed {
			logic       spare;
			logic [6:0] pos;
		} spin;
	} port_byte_u;

	typedef struct packed {
		logic [7:0] in0;
		port_byte_u in1;
		logic [7:0] in2;
		logic [7:0] in3;
		logic [7:0] in4;
	} cabinet_ports_t;

	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} audio_pair_t;

endpackage

//--- input/input_mapper.sv
// Cabinet input port mapper
`timescale 1ns/10ps

module input_mapper
	import mcr3_pkg::*;
(
	input  logic                clk_sys,
	input  logic                arst_n,
	input  game_t               game,
	input  logic [7:0]          dip0,
	input  logic                service,
	input  joy_word_t           joy1,
	input  joy_word_t           joy2,
	input  logic [spin_w-1:0]   sp1,
	input  logic [spin_w-1:0]   sp2,
	output cabinet_ports_t      ports,
	output logic                landscape
);

	logic [spin_w-1:0] sp1_prev;
	logic [spin_w-1:0] sp2_prev;
	logic [spin_w-1:0] sp_pos;
	logic              sp_sel;
	joy_word_t         joy_any;
	logic              coin;
	cabinet_ports_t    ports_next;
	logic              landscape_next;

	// Last spinner to move wins
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sp1_prev <= '0;
			sp2_prev <= '0;
			sp_sel   <= 1'b0;
			sp_pos   <= '0;
		end else begin
			sp1_prev <= sp1;
			sp2_prev <= sp2;
			if (sp1_prev != sp1)
				sp_sel <= 1'b0;
			if (sp2_prev != sp2)
				sp_sel <= 1'b1;
			sp_pos <= sp_sel ? sp2 : sp1;
		end
	end

	assign joy_any = joy1 | joy2;
	// Dotron counts a start press as a coin too
	assign coin = joy_any.coin |
		((game == game_dotron) & (joy_any.start1 | joy_any.start2));

	// ======================================================================
	// Per-game port layout, all active low
	// ======================================================================

	always_comb begin
		landscape_next = 1'b1;
		ports_next.in0     = 8'hff;
		ports_next.in1.btn = 8'hff;
		ports_next.in2     = 8'hff;
		ports_next.in3     = dip0;
		ports_next.in4     = 8'hff;
		case (game)
			game_tapper: begin
				ports_next.in0 = ~{service, 3'b000, joy_any.start2, joy_any.start1, 1'b0, coin};
				ports_next.in1.btn = ~{3'b000, joy_any.fire_a, joy_any.up, joy_any.down,
					joy_any.left, joy_any.right};
				ports_next.in2 = ~{3'b000, joy_any.fire_a, joy_any.up, joy_any.down,
					joy_any.left, joy_any.right};
			end
			game_timber: begin
				ports_next.in0 = ~{service, 3'b000, joy_any.start2, joy_any.start1, 1'b0, coin};
				ports_next.in1.btn = ~{2'b00, joy1.fire_a, joy1.fire_b, joy1.up, joy1.down,
					joy1.left, joy1.right};
				ports_next.in2 = ~{2'b00, joy2.fire_a, joy2.fire_b, joy2.up, joy2.down,
					joy2.left, joy2.right};
			end
			game_dotron: begin
				ports_next.in0 = ~{service, 2'b00, joy_any.fire_a, joy_any.start2,
					joy_any.start1, 1'b0, coin};
				ports_next.in1.spin.spare = 1'b1;
				ports_next.in1.spin.pos   = ~sp_pos[7:1];
				ports_next.in2 = ~{1'b0, joy_any.fire_b, joy_any.fire_c, joy_any.fire_d,
					joy_any.down, joy_any.up, joy_any.right, joy_any.left};
			end
			game_journey: begin
				landscape_next = 1'b0;
				ports_next.in0 = ~{service, 2'b00, joy_any.fire_a, joy_any.start2,
					joy_any.start1, 1'b0, coin};
				ports_next.in1.btn = ~{4'b0000, joy_any.down, joy_any.up, joy_any.right,
					joy_any.left};
				ports_next.in2 = ~{3'b000, joy_any.fire_a, joy_any.down, joy_any.up,
					joy_any.right, joy_any.left};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ports     <= '1;
			landscape <= 1'b1;
		end else begin
			ports     <= ports_next;
			landscape <= landscape_next;
		end
	end

endmodule

//--- loader/download_decoder.sv
// Download stream decoder
`timescale 1ns/10ps

module download_decoder
	import mcr3_pkg::*;
#(
	parameter logic [15:0] reset_hold = 16'hffff
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  dl_write_t  dl,
	input  logic       reset_req,
	output game_t      game,
	output logic [7:0] dip0,
	output logic       game_reset,
	output logic       rom_loaded
);

	logic        rom_download;
	logic        rom_download_d;
	logic [7:0]  mode_q;
	logic [7:0]  dip [8];
	logic [15:0] reset_count;

	assign rom_download = dl.download && (dl.index == idx_rom);
	assign dip0         = dip[0];

	// ======================================================================
	// Game select and DIP bytes
	// ======================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mode_q <= 8'd0;
			game   <= game_tapper;
		end else begin
			if (dl.wr && (dl.index == idx_mode))
				mode_q <= dl.data;
			game <= game_t'(mode_q);
		end
	end

	// Only the first eight addresses land in the DIP bank
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				dip[i] <= 8'hff;
		end else if (dl.wr && (dl.index == idx_dip) && (dl.addr[24:3] == '0)) begin
			dip[dl.addr[2:0]] <= dl.data;
		end
	end

	// ======================================================================
	// ROM load detect and game reset
	// ======================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_download_d <= 1'b0;
			rom_loaded     <= 1'b0;
			reset_count    <= reset_hold;
			game_reset     <= 1'b1;
		end else begin
			rom_download_d <= rom_download;
			// End of the ROM burst
			if (rom_download_d && !rom_download)
				rom_loaded <= 1'b1;

			// Countdown for the late second reset pulse
			if (reset_req || rom_download || !rom_loaded)
				reset_count <= reset_hold;
			else if (reset_count != 16'd0)
				reset_count <= reset_count - 16'd1;

			game_reset <= reset_req | rom_download | ~rom_loaded |
				(reset_count == 16'd1);
		end
	end

endmodule

//--- mcr3_control.f
common/mcr3_pkg.sv
loader/download_decoder.sv
input/input_mapper.sv
src/audio_mixer.sv
src/mcr3_control.sv
tb/mcr3_control_sva.sv
tb/mcr3_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, the exit status carries the result
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module mcr3_control_tb \
		-f mcr3_control.f -o mcr3_control_sim &&
	./obj_dir/mcr3_control_sim || exit 1

//--- src/audio_mixer.sv
// PCM and game audio mixer
`timescale 1ns/10ps

module audio_mixer
	import mcr3_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  game_t       game,
	input  audio_pair_t game_audio,
	input  audio_pair_t pcm,
	output audio_pair_t audio_out,
	output logic        audio_signed
);

	logic is_journey;

	// Half of the signed PCM plus the unsigned game sample
	function automatic logic [15:0] mix_sat(input logic [15:0] pcm_s, input logic [15:0] game_s);
		logic [16:0] sum;
		sum = {{2{pcm_s[15]}}, pcm_s[15:1]} + {1'b0, game_s};
		// Top two bits disagree on overflow
		if (sum[16] ^ sum[15])
			return {sum[16], {15{~sum[16]}}};
		else
			return sum[15:0];
	endfunction

	assign is_journey   = (game == game_journey);
	assign audio_signed = is_journey;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			audio_out <= '0;
		end else if (is_journey) begin
			audio_out.left  <= mix_sat(pcm.left, game_audio.left);
			audio_out.right <= mix_sat(pcm.right, game_audio.right);
		end else begin
			audio_out <= game_audio;
		end
	end

endmodule

//--- src/mcr3_control.sv
// MCR3 cabinet control top level
`timescale 1ns/10ps

module mcr3_control
	import mcr3_pkg::*;
#(
	parameter logic [15:0] reset_hold = 16'hffff
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  dl_write_t         dl,
	input  logic              reset_req,
	input  logic              service,
	input  joy_word_t         joy1,
	input  joy_word_t         joy2,
	input  logic [spin_w-1:0] sp1,
	input  logic [spin_w-1:0] sp2,
	input  audio_pair_t       game_audio,
	input  audio_pair_t       pcm,
	output cabinet_ports_t    ports,
	output logic              landscape,
	output logic              game_reset,
	output logic              rom_loaded,
	output audio_pair_t       audio_out,
	output logic              audio_signed
);

	game_t      game;
	logic [7:0] dip0;

	download_decoder #(
		.reset_hold(reset_hold)
	) u_decoder (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.reset_req  (reset_req),
		.game       (game),
		.dip0       (dip0),
		.game_reset (game_reset),
		.rom_loaded (rom_loaded)
	);

	input_mapper u_mapper (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.game      (game),
		.dip0      (dip0),
		.service   (service),
		.joy1      (joy1),
		.joy2      (joy2),
		.sp1       (sp1),
		.sp2       (sp2),
		.ports     (ports),
		.landscape (landscape)
	);

	audio_mixer u_mixer (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.game         (game),
		.game_audio   (game_audio),
		.pcm          (pcm),
		.audio_out    (audio_out),
		.audio_signed (audio_signed)
	);

endmodule

//--- tb/mcr3_control_sva.sv
// MCR3 control bound assertions
`timescale 1ns/10ps

module mcr3_control_sva
	import mcr3_pkg::*;
(
	input logic      clk_sys,
	input logic      arst_n,
	input dl_write_t dl,
	input logic      game_reset,
	input logic      rom_loaded,
	input logic      landscape,
	input logic      audio_signed
);

	// Game stays in reset while ROM data streams in
	a_reset_during_rom: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		(dl.download && (dl.index == idx_rom)) |=> game_reset
	) else $error("game_reset low during ROM download");

	// Once loaded, the ROM stays loaded
	a_rom_loaded_sticky: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		rom_loaded |=> rom_loaded
	) else $error("rom_loaded fell after being set");

	// Journey is the signed game and the one portrait game, landscape lags a cycle
	a_signed_on_journey: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		landscape == !$past(audio_signed)
	) else $error("audio_signed does not match the journey orientation");

endmodule

//--- tb/mcr3_control_tb.sv
// MCR3 control testbench
`timescale 1ns/10ps

module mcr3_control_tb
	import mcr3_pkg::*;
();

	localparam int num_rows       = 16;
	localparam int timeout_cycles = 2 * num_rows * 8 + 200;

	typedef struct packed {
		logic [7:0]        game;
		joy_word_t         joy1;
		joy_word_t         joy2;
		logic              service;
		logic [spin_w-1:0] sp1;
		logic [spin_w-1:0] sp2;
		audio_pair_t       game_audio;
		audio_pair_t       pcm;
	} row_t;

	logic              clk_sys = 1'b0;
	logic              arst_n;
	dl_write_t         dl;
	logic              reset_req;
	logic              service;
	joy_word_t         joy1;
	joy_word_t         joy2;
	logic [spin_w-1:0] sp1;
	logic [spin_w-1:0] sp2;
	audio_pair_t       game_audio;
	audio_pair_t       pcm;
	cabinet_ports_t    ports;
	logic              landscape;
	logic              game_reset;
	logic              rom_loaded;
	audio_pair_t       audio_out;
	logic              audio_signed;

	row_t              rows [$];
	logic [31:0]       rng_state = 32'd29875;
	logic [spin_w-1:0] cur_sp1;
	logic [spin_w-1:0] cur_sp2;
	logic              spin_sel;
	logic [7:0]        dip0_exp;
	int                cycle_count = 0;
	int                gap;

	mcr3_control #(
		.reset_hold(16'd20)
	) dut0 (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.reset_req    (reset_req),
		.service      (service),
		.joy1         (joy1),
		.joy2         (joy2),
		.sp1          (sp1),
		.sp2          (sp2),
		.game_audio   (game_audio),
		.pcm          (pcm),
		.ports        (ports),
		.landscape    (landscape),
		.game_reset   (game_reset),
		.rom_loaded   (rom_loaded),
		.audio_out    (audio_out),
		.audio_signed (audio_signed)
	);

	bind mcr3_control mcr3_control_sva sva0 (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.game_reset   (game_reset),
		.rom_loaded   (rom_loaded),
		.landscape    (landscape),
		.audio_signed (audio_signed)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
			$display("Simulation failed");
			$fatal(1, "run timed out");
		end
	end

	// ======================================================================
	// Reference model and random source
	// ======================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Half the signed PCM plus the unsigned game sample, the sum wraps at 17 bits
	function automatic logic [15:0] mix_expect(input logic [15:0] pcm_s, input logic [15:0] game_s);
		int half;
		int total;
		half  = int'($signed(pcm_s)) >>> 1;
		total = half + int'(game_s);
		if (total > 65535)
			total = total - 131072;
		if (total > 32767)
			return 16'h7fff;
		else if (total < -32768)
			return 16'h8000;
		else
			return total[15:0];
	endfunction

	// Active-high button bytes per game, inverted at the end
	function automatic cabinet_ports_t expect_ports(input logic [7:0] game, input joy_word_t p1,
			input joy_word_t p2, input logic svc, input logic [spin_w-1:0] spin,
			input logic [7:0] dip);
		joy_word_t      both;
		logic           coin_any;
		logic [7:0]     hi0;
		logic [7:0]     hi1;
		logic [7:0]     hi2;
		cabinet_ports_t want;
		both     = p1 | p2;
		coin_any = both.coin | ((game == game_dotron) & (both.start1 | both.start2));
		hi0 = 8'h00;
		hi1 = 8'h00;
		hi2 = 8'h00;
		case (game)
			game_tapper: begin
				hi0 = {svc, 3'b000, both.start2, both.start1, 1'b0, coin_any};
				hi1 = {3'b000, both.fire_a, both.up, both.down, both.left, both.right};
				hi2 = hi1;
			end
			game_timber: begin
				hi0 = {svc, 3'b000, both.start2, both.start1, 1'b0, coin_any};
				hi1 = {2'b00, p1.fire_a, p1.fire_b, p1.up, p1.down, p1.left, p1.right};
				hi2 = {2'b00, p2.fire_a, p2.fire_b, p2.up, p2.down, p2.left, p2.right};
			end
			game_dotron: begin
				hi0 = {svc, 2'b00, both.fire_a, both.start2, both.start1, 1'b0, coin_any};
				hi1 = {1'b0, spin[7:1]};
				hi2 = {1'b0, both.fire_b, both.fire_c, both.fire_d, both.down, both.up,
					both.right, both.left};
			end
			game_journey: begin
				hi0 = {svc, 2'b00, both.fire_a, both.start2, both.start1, 1'b0, coin_any};
				hi1 = {4'b0000, both.down, both.up, both.right, both.left};
				hi2 = {3'b000, both.fire_a, both.down, both.up, both.right, both.left};
			end
			default: ;
		endcase
		want.in0     = ~hi0;
		want.in1.btn = ~hi1;
		want.in2     = ~hi2;
		want.in3     = dip;
		want.in4     = 8'hff;
		return want;
	endfunction

	// ======================================================================
	// Checks and drivers
	// ======================================================================

	task automatic check_ports(input string what, input cabinet_ports_t got,
			input cabinet_ports_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Simulation failed");
			$fatal(1, "ports mismatch");
		end
	endtask

	task automatic check_audio(input string what, input audio_pair_t got, input audio_pair_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Simulation failed");
			$fatal(1, "audio mismatch");
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, want);
			$display("Simulation failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic write_beat(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		@(posedge clk_sys);
		dl.wr    <= 1'b1;
		dl.index <= index;
		dl.addr  <= addr;
		dl.data  <= data;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
	endtask

	// Each row moves exactly one spinner so the last mover is always known
	task automatic build_rows();
		row_t              r;
		logic [31:0]       rnd;
		logic              move_sp2;
		logic [spin_w-1:0] last_sp1;
		logic [spin_w-1:0] last_sp2;
		last_sp1 = '0;
		last_sp2 = '0;
		for (int i = 0; i < num_rows; i++) begin
			r.game       = (i == 14) ? 8'd7 : 8'(i % 4);
			r.joy1       = next_rand();
			r.joy2       = next_rand();
			r.game_audio = next_rand();
			rnd          = next_rand();
			r.pcm        = {rnd[15:0], rnd[15:0]};
			rnd          = next_rand();
			r.service    = rnd[0];
			move_sp2     = (i == 2) ? 1'b1 : (i == 6) ? 1'b0 : rnd[31];
			if (move_sp2)
				last_sp2 = last_sp2 ^ {rnd[8:2], 2'b10};
			else
				last_sp1 = last_sp1 ^ {rnd[18:12], 2'b10};
			r.sp1 = last_sp1;
			r.sp2 = last_sp2;
			// Journey rows 3 and 7 push the mixer into both clamp limits
			if (i == 3) begin
				r.pcm        = {2{16'h4000}};
				r.game_audio = {16'hc000, 16'h9000};
			end
			if (i == 7) begin
				r.pcm        = {2{16'h7ffe}};
				r.game_audio = {16'hffff, 16'hf000};
			end
			rows.push_back(r);
		end
	endtask

	task automatic apply_row(input int n, input row_t r);
		audio_pair_t want_audio;
		if (r.sp1 != cur_sp1)
			spin_sel = 1'b0;
		if (r.sp2 != cur_sp2)
			spin_sel = 1'b1;
		cur_sp1 = r.sp1;
		cur_sp2 = r.sp2;
		@(posedge clk_sys);
		joy1       <= r.joy1;
		joy2       <= r.joy2;
		service    <= r.service;
		sp1        <= r.sp1;
		sp2        <= r.sp2;
		game_audio <= r.game_audio;
		pcm        <= r.pcm;
		write_beat(idx_mode, 25'd0, r.game);
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_ports($sformatf("row %0d ports", n), ports, expect_ports(r.game, r.joy1, r.joy2,
			r.service, spin_sel ? cur_sp2 : cur_sp1, dip0_exp));
		check_bit($sformatf("row %0d landscape", n), landscape, r.game != game_journey);
		check_bit($sformatf("row %0d audio_signed", n), audio_signed, r.game == game_journey);
		if (r.game == game_journey) begin
			want_audio.left  = mix_expect(r.pcm.left, r.game_audio.left);
			want_audio.right = mix_expect(r.pcm.right, r.game_audio.right);
		end else begin
			want_audio = r.game_audio;
		end
		check_audio($sformatf("row %0d audio_out", n), audio_out, want_audio);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		arst_n     = 1'b1;
		dl         = '0;
		reset_req  = 1'b0;
		service    = 1'b0;
		joy1       = '0;
		joy2       = '0;
		sp1        = '0;
		sp2        = '0;
		game_audio = '0;
		pcm        = '0;
		cur_sp1    = '0;
		cur_sp2    = '0;
		spin_sel   = 1'b0;
		dip0_exp   = 8'hff;
		build_rows();
		// Reset edge just after time zero
		#1 arst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("game_reset in reset", game_reset, 1'b1);
		check_bit("rom_loaded in reset", rom_loaded, 1'b0);
		check_ports("ports in reset", ports, '1);
		check_audio("audio_out in reset", audio_out, '0);
		@(posedge clk_sys);
		arst_n <= 1'b1;

		// No ROM yet, so the game is held in reset
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("game_reset before load", game_reset, 1'b1);
		check_bit("rom_loaded before load", rom_loaded, 1'b0);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= idx_rom;
		for (int a = 0; a < 4; a++)
			write_beat(idx_rom, 25'(a), 8'(8'h40 + a));
		@(posedge clk_sys);
		dl.download <= 1'b0;
		while (rom_loaded !== 1'b1)
			@(negedge clk_sys);
		while (game_reset !== 1'b0)
			@(negedge clk_sys);
		gap = 0;
		while (game_reset === 1'b0) begin
			@(negedge clk_sys);
			gap++;
		end
		if (gap < 18 || gap > 22) begin
			$display("ERROR at %0t: second reset pulse after %0d cycles, expected 18 to 22",
				$time, gap);
			$display("Simulation failed");
			$fatal(1, "reset pulse timing");
		end
		@(negedge clk_sys);
		check_bit("game_reset after pulse", game_reset, 1'b0);
		repeat (30) begin
			@(negedge clk_sys);
			check_bit("game_reset after load", game_reset, 1'b0);
		end

		// DIP byte 0 reaches in3, addresses 8 and 9 are outside the bank
		write_beat(idx_dip, 25'd0, 8'h5a);
		dip0_exp = 8'h5a;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_ports("ports after DIP write", ports,
			expect_ports(game_tapper, '0, '0, 1'b0, '0, dip0_exp));
		write_beat(idx_dip, 25'd8, 8'h33);
		write_beat(idx_dip, 25'd9, 8'h33);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_ports("ports after DIP writes to addresses 8 and 9", ports,
			expect_ports(game_tapper, '0, '0, 1'b0, '0, dip0_exp));

		foreach (rows[i])
			apply_row(i, rows[i]);

		$display("Simulation passed");
		$finish;
	end

endmodule
